/* design/l2_cache_pkg.sv */
`default_nettype none

package l2_cache_pkg;

    // ====================================================================
    // Cache geometry
    // ====================================================================
    localparam int XLEN       = 32;                  // Byte address width
    localparam int LINE_W     = 128;                 // One cache line
    localparam int N_WAYS     = 4;                   // Fixed associativity
    localparam int WAY_W      = $clog2(N_WAYS);
    localparam int OFFSET_W   = $clog2(LINE_W / 8);  // Byte offset inside a line
    localparam int N_SETS_DEF = 16;                  // Top level may override

    // ====================================================================
    // Common types
    // ====================================================================
    typedef logic [XLEN-1:0]   addr_t;   // Byte address
    typedef logic [LINE_W-1:0] line_t;   // Whole line payload
    typedef logic [WAY_W-1:0]  way_t;    // Way select

    // Controller FSM
    typedef enum logic [1:0] {
        IDLE   = 2'd0,   // Wait for a request
        LOOKUP = 2'd1,   // Array outputs valid, pick hit, evict or fill
        WB_MEM = 2'd2,   // Dirty victim goes out to memory
        RD_MEM = 2'd3    // Line fill from memory
    } ctrl_state_e;

endpackage

`default_nettype wire

/* design/l2_array_if.sv */
`default_nettype none

interface l2_array_if #(
    parameter int N_SETS = l2_cache_pkg::N_SETS_DEF
);
    import l2_cache_pkg::*;

    localparam int SET_W = $clog2(N_SETS);

    // Driven by the controller
    addr_t            addr;          // Lookup address, stable for a whole request
    logic             write_en;      // Store tag, state and line
    way_t             write_way;     // Target way of the store
    line_t            write_line;
    logic             write_dirty;   // Dirty bit that goes with the store
    logic             fill_done;     // Victim slot refilled, FIFO moves on

    // Driven by the storage blocks
    logic             hit;
    way_t             hit_way;
    logic             victim_valid;
    logic             victim_dirty;
    addr_t            victim_addr;   // Rebuilt line address of the victim
    logic             sweep_busy;    // Valid bits still being cleared
    line_t            hit_line;
    line_t            victim_line;
    way_t             victim_way;

    logic [SET_W-1:0] set_idx;       // Shared by all arrays

    assign set_idx = addr[OFFSET_W +: SET_W];

    modport ctrl (output addr, write_en, write_way, write_line, write_dirty, fill_done,
                  input hit, hit_way, victim_valid, victim_dirty, victim_addr,
                  input sweep_busy, hit_line, victim_line, victim_way);
    modport tags (input addr, set_idx, write_en, write_way, write_dirty, victim_way,
                  output hit, hit_way, victim_valid, victim_dirty, victim_addr, sweep_busy);
    modport data (input set_idx, write_en, write_way, write_line, hit_way, victim_way,
                  output hit_line, victim_line);
    modport repl (input set_idx, fill_done, output victim_way);

endinterface

`default_nettype wire

/* design/l2_tag_array.sv */
`default_nettype none

module l2_tag_array #(
    parameter int N_SETS = l2_cache_pkg::N_SETS_DEF
) (
    input  wire logic clk_i,
    input  wire logic rst_i,
    l2_array_if.tags  arr
);
    import l2_cache_pkg::*;

    localparam int SET_W = $clog2(N_SETS);
    localparam int TAG_W = XLEN - SET_W - OFFSET_W;

    logic [TAG_W-1:0]  tag_mem   [N_WAYS][N_SETS];
    logic [N_WAYS-1:0] valid_mem [N_SETS];         // One bit per way
    logic [N_WAYS-1:0] dirty_mem [N_SETS];

    logic [TAG_W-1:0]  tag_q [N_WAYS];             // Registered read port
    logic [N_WAYS-1:0] valid_q;
    logic [N_WAYS-1:0] dirty_q;
    logic [N_WAYS-1:0] way_hit;
    logic [TAG_W-1:0]  lookup_tag;
    logic [SET_W-1:0]  sweep_cnt;                  // Set being cleared
    logic              sweep_busy;

    assign lookup_tag     = arr.addr[XLEN-1 -: TAG_W];
    assign arr.sweep_busy = sweep_busy;

    // ====================================================================
    // Valid sweep after reset, one set per cycle
    // ====================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sweep_cnt  <= '0;
            sweep_busy <= 1'b1;
        end else if (sweep_busy) begin
            sweep_cnt  <= sweep_cnt + 1'b1;
            sweep_busy <= (sweep_cnt != SET_W'(N_SETS - 1)); // Done after last set
        end
    end

    // Tags, read one cycle after the address
    always_ff @(posedge clk_i) begin
        if (arr.write_en) begin
            tag_mem[arr.write_way][arr.set_idx] <= lookup_tag;
        end
        for (int w = 0; w < N_WAYS; w++) begin
            tag_q[w] <= tag_mem[w][arr.set_idx];
        end
    end

    // Valid and dirty bits, the sweep has priority over stores
    always_ff @(posedge clk_i) begin
        if (sweep_busy) begin
            valid_mem[sweep_cnt] <= '0;
            dirty_mem[sweep_cnt] <= '0;
            valid_q              <= '0;  // Nothing valid until the sweep ends
            dirty_q              <= '0;
        end else begin
            if (arr.write_en) begin
                valid_mem[arr.set_idx][arr.write_way] <= 1'b1;
                dirty_mem[arr.set_idx][arr.write_way] <= arr.write_dirty;
            end
            valid_q <= valid_mem[arr.set_idx];
            dirty_q <= dirty_mem[arr.set_idx];
        end
    end

    // ====================================================================
    // Compare and hit-way encode
    // ====================================================================
    always_comb begin
        arr.hit_way = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            way_hit[w] = valid_q[w] && (tag_q[w] == lookup_tag);
            if (way_hit[w]) begin
                arr.hit_way = way_t'(w);
            end
        end
    end

    assign arr.hit          = |way_hit;
    assign arr.victim_valid = valid_q[arr.victim_way];
    assign arr.victim_dirty = dirty_q[arr.victim_way];
    assign arr.victim_addr  = {tag_q[arr.victim_way], arr.set_idx, {OFFSET_W{1'b0}}};

    // A line is only ever allocated on a miss, so no two ways may match
    assert property (@(posedge clk_i) disable iff (rst_i || sweep_busy) $onehot0(way_hit))
        else $error("l2_tag_array: more than one way hit");

endmodule

`default_nettype wire

/* design/l2_data_array.sv */
`default_nettype none

module l2_data_array #(
    parameter int N_SETS = l2_cache_pkg::N_SETS_DEF
) (
    input  wire logic clk_i,
    l2_array_if.data  arr
);
    import l2_cache_pkg::*;

    line_t data_mem [N_WAYS][N_SETS];   // Line storage, way major
    line_t rd_q     [N_WAYS];           // All ways of the addressed set

    // One write port, one synchronous read port over all ways
    always_ff @(posedge clk_i) begin
        if (arr.write_en) begin
            data_mem[arr.write_way][arr.set_idx] <= arr.write_line;
        end
        for (int w = 0; w < N_WAYS; w++) begin
            rd_q[w] <= data_mem[w][arr.set_idx];  // Old data on a same-cycle store
        end
    end

    // Way selects arrive with the registered tags and FIFO state
    assign arr.hit_line    = rd_q[arr.hit_way];
    assign arr.victim_line = rd_q[arr.victim_way];  // Write-back payload

endmodule

`default_nettype wire

/* design/l2_fifo_repl.sv */
`default_nettype none

module l2_fifo_repl #(
    parameter int N_SETS = l2_cache_pkg::N_SETS_DEF
) (
    input  wire logic clk_i,
    input  wire logic rst_i,
    l2_array_if.repl  arr
);
    import l2_cache_pkg::*;

    way_t fifo_cnt [N_SETS];   // Next way to replace, per set

    // Round robin over the ways, so the oldest fill goes first
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < N_SETS; s++) begin
                fifo_cnt[s] <= '0;
            end
        end else if (arr.fill_done) begin
            fifo_cnt[arr.set_idx] <= fifo_cnt[arr.set_idx] + way_t'(1);  // Wraps at 4
        end
    end

    // Registered like the arrays so it lines up in LOOKUP
    always_ff @(posedge clk_i) begin
        arr.victim_way <= fifo_cnt[arr.set_idx];
    end

endmodule

`default_nettype wire

/* design/l2_ctrl.sv */
`default_nettype none

module l2_ctrl (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    // Request port
    input  wire logic                req_strobe_i,
    input  wire logic                req_wb_i,      // 1 write-back, 0 read
    input  wire l2_cache_pkg::addr_t req_addr_i,
    input  wire l2_cache_pkg::line_t req_data_i,
    output logic                     resp_ready_o,
    output l2_cache_pkg::line_t      resp_data_o,
    // Memory port
    output logic                     m_strobe_o,
    output logic                     m_rw_o,        // 1 write
    output l2_cache_pkg::addr_t      m_addr_o,
    output l2_cache_pkg::line_t      m_data_o,
    input  wire logic                m_ready_i,
    input  wire l2_cache_pkg::line_t m_data_i,
    // Storage blocks
    l2_array_if.ctrl                 arr
);
    import l2_cache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        dirty_victim;   // Victim must reach memory before reuse

    assign dirty_victim = arr.victim_valid && arr.victim_dirty;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ====================================================================
    // Next state, response and store strobes
    // ====================================================================
    always_comb begin
        state_d       = state_q;
        resp_ready_o  = 1'b0;
        arr.write_en  = 1'b0;
        arr.fill_done = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_strobe_i && !arr.sweep_busy) begin  // Arrays read this cycle
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (arr.hit) begin
                    resp_ready_o = 1'b1;
                    arr.write_en = req_wb_i;       // Write-back hit overwrites the line
                    state_d      = IDLE;
                end else if (dirty_victim) begin
                    state_d = WB_MEM;
                end else if (req_wb_i) begin       // Clean victim takes the line in place
                    resp_ready_o  = 1'b1;
                    arr.write_en  = 1'b1;
                    arr.fill_done = 1'b1;
                    state_d       = IDLE;
                end else begin
                    state_d = RD_MEM;
                end
            end
            WB_MEM: begin
                if (m_ready_i) begin
                    if (req_wb_i) begin            // Slot now free for the write-back
                        resp_ready_o  = 1'b1;
                        arr.write_en  = 1'b1;
                        arr.fill_done = 1'b1;
                        state_d       = IDLE;
                    end else begin
                        state_d = RD_MEM;
                    end
                end
            end
            RD_MEM: begin
                if (m_ready_i) begin               // Fill and answer at once
                    resp_ready_o  = 1'b1;
                    arr.write_en  = 1'b1;
                    arr.fill_done = 1'b1;
                    state_d       = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // Store path
    assign arr.addr        = req_addr_i;
    assign arr.write_way   = (state_q == LOOKUP && arr.hit) ? arr.hit_way : arr.victim_way;
    assign arr.write_line  = (state_q == RD_MEM) ? m_data_i : req_data_i;
    assign arr.write_dirty = req_wb_i;   // Fills from memory are clean

    // ====================================================================
    // Memory port held until the ready pulse
    // ====================================================================
    assign m_strobe_o = (state_q == WB_MEM || state_q == RD_MEM) && !m_ready_i;
    assign m_rw_o     = (state_q == WB_MEM);
    assign m_data_o   = arr.victim_line;            // Only used with m_rw_o
    always_comb begin
        case (state_q)
            WB_MEM:  m_addr_o = arr.victim_addr;
            RD_MEM:  m_addr_o = {req_addr_i[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
            default: m_addr_o = '0;
        endcase
    end

    // Read data from the hit way or straight from memory
    always_comb begin
        if (state_q == LOOKUP && arr.hit && !req_wb_i) begin
            resp_data_o = arr.hit_line;
        end else if (state_q == RD_MEM && m_ready_i) begin
            resp_data_o = m_data_i;
        end else begin
            resp_data_o = '0;
        end
    end

    // Request stays up with fixed address and direction until memory answers
    assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_o |=> m_ready_i || (m_strobe_o && $stable(m_addr_o) && $stable(m_rw_o)))
        else $error("l2_ctrl: memory request dropped or changed");

    // Lookup results stay valid only while the requester holds its request
    assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q != IDLE) |-> req_strobe_i && $stable(req_addr_i) && $stable(req_wb_i))
        else $error("l2_ctrl: request changed before the response");

    // Nothing leaves the controller while idle
    assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == IDLE) |-> !resp_ready_o && !m_strobe_o)
        else $error("l2_ctrl: output active in IDLE");

endmodule

`default_nettype wire

/* design/l2_cache.sv */
`default_nettype none

module l2_cache #(
    parameter int N_SETS = l2_cache_pkg::N_SETS_DEF
) (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    // Request side
    input  wire logic                req_strobe_i,
    input  wire logic                req_wb_i,
    input  wire l2_cache_pkg::addr_t req_addr_i,
    input  wire l2_cache_pkg::line_t req_data_i,
    output logic                     resp_ready_o,
    output l2_cache_pkg::line_t      resp_data_o,
    // Main memory side
    output logic                     m_strobe_o,
    output logic                     m_rw_o,
    output l2_cache_pkg::addr_t      m_addr_o,
    output l2_cache_pkg::line_t      m_data_o,
    input  wire logic                m_ready_i,
    input  wire l2_cache_pkg::line_t m_data_i
);

    // ====================================================================
    // Controller to storage bundle
    // ====================================================================
    l2_array_if #(.N_SETS(N_SETS)) arr ();

    // Tags, valid and dirty bits, hit detect
    l2_tag_array #(.N_SETS(N_SETS)) tag_array_i (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .arr   (arr.tags)
    );

    // Line payloads
    l2_data_array #(.N_SETS(N_SETS)) data_array_i (
        .clk_i (clk_i),
        .arr   (arr.data)
    );

    // Victim choice
    l2_fifo_repl #(.N_SETS(N_SETS)) fifo_repl_i (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .arr   (arr.repl)
    );

    l2_ctrl ctrl_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_strobe_i (req_strobe_i),
        .req_wb_i     (req_wb_i),
        .req_addr_i   (req_addr_i),
        .req_data_i   (req_data_i),
        .resp_ready_o (resp_ready_o),
        .resp_data_o  (resp_data_o),
        .m_strobe_o   (m_strobe_o),
        .m_rw_o       (m_rw_o),
        .m_addr_o     (m_addr_o),
        .m_data_o     (m_data_o),
        .m_ready_i    (m_ready_i),
        .m_data_i     (m_data_i),
        .arr          (arr.ctrl)
    );

endmodule

`default_nettype wire

/* tb/tb_l2_cache.sv */
`default_nettype none

module tb_l2_cache;
    import l2_cache_pkg::*;

    localparam int N_SETS  = 16;
    localparam int SET_W   = $clog2(N_SETS);
    localparam int TIMEOUT = 200;            // Cycles allowed per handshake

    logic  clk_i;
    logic  rst_i;
    logic  req_strobe_i;
    logic  req_wb_i;
    addr_t req_addr_i;
    line_t req_data_i;
    logic  resp_ready_o;
    line_t resp_data_o;
    logic  m_strobe_o;
    logic  m_rw_o;
    addr_t m_addr_o;
    line_t m_data_o;
    logic  m_ready_i;
    line_t m_data_i;

    integer seed       = 23;
    line_t  mem_lines [addr_t];              // Memory model contents
    line_t  wb_lines  [addr_t];              // Last write-back per line

    // Cache model mirroring tags and FIFO order
    addr_t  way_addr  [N_SETS][N_WAYS];
    logic   way_valid [N_SETS][N_WAYS];
    logic   way_dirty [N_SETS][N_WAYS];
    way_t   fifo_cnt  [N_SETS];

    logic   exp_rw   [$];                    // Expected memory accesses in issue order
    addr_t  exp_addr [$];
    logic   exp_check;                       // Read data due on this response
    line_t  exp_line;
    string  test_name;

    l2_cache #(.N_SETS(N_SETS)) l2_cache_i (.*);

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    // ====================================================================
    // Reference model and compare tasks
    // ====================================================================
    function automatic line_t pattern_line(addr_t a);
        return {a ^ 32'hc3a5_5a3c, ~a, {a[15:0], a[31:16]}, a * 32'd2654435761};
    endfunction

    // Dirty lines plus memory always give this value in a write-back cache
    function automatic line_t ref_line(addr_t a);
        if (wb_lines.exists(a)) return wb_lines[a];
        if (mem_lines.exists(a)) return mem_lines[a];
        return pattern_line(a);
    endfunction

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation aborted");
    endtask

    task automatic check_line(string name, line_t exp, line_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "line mismatch");
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            $display("Test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Read data check on every read response
    always @(negedge clk_i) begin
        if (resp_ready_o && exp_check) begin
            check_line(test_name, exp_line, resp_data_o);
        end
    end

    // ====================================================================
    // Memory model with one ready pulse 1 to 4 cycles after the strobe
    // ====================================================================
    initial begin : memory_model
        int    delay;
        addr_t a;
        line_t rdata;
        m_ready_i = 1'b0;
        m_data_i  = '0;
        forever begin
            @(negedge clk_i);
            if (m_strobe_o) begin
                a = m_addr_o;
                if (exp_rw.size() == 0) abort_run("Memory access that no request needed");
                check_bit({test_name, " mem rw"}, exp_rw.pop_front(), m_rw_o);
                check_addr({test_name, " mem addr"}, exp_addr.pop_front(), a);
                if (m_rw_o) begin
                    check_line({test_name, " mem data"}, ref_line(a), m_data_o);
                    mem_lines[a] = m_data_o;
                    rdata = '0;
                end else begin
                    rdata = mem_lines.exists(a) ? mem_lines[a] : pattern_line(a);
                end
                delay = 1 + ({$random(seed)} % 4);
                repeat (delay) @(posedge clk_i);
                #2;
                m_ready_i = 1'b1;
                m_data_i  = rdata;
                @(posedge clk_i);
                #2;
                m_ready_i = 1'b0;                // Single cycle pulse
                m_data_i  = '0;
            end
        end
    end

    // ====================================================================
    // Request driver that predicts memory traffic from the cache model
    // ====================================================================
    task automatic do_request(string name, logic wb, addr_t a, line_t data);
        int    set;
        int    v;
        int    hit_w;
        int    cycles;
        addr_t la;
        la    = {a[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
        set   = int'(la[OFFSET_W +: SET_W]);
        hit_w = -1;
        for (int w = 0; w < N_WAYS; w++) begin
            if (way_valid[set][w] && way_addr[set][w] == la) begin
                hit_w = w;
            end
        end
        if (hit_w < 0) begin                     // Miss takes the FIFO victim
            v = int'(fifo_cnt[set]);
            if (way_valid[set][v] && way_dirty[set][v]) begin
                exp_rw.push_back(1'b1);
                exp_addr.push_back(way_addr[set][v]);
            end
            if (!wb) begin
                exp_rw.push_back(1'b0);
                exp_addr.push_back(la);
            end
            way_addr[set][v]  = la;
            way_valid[set][v] = 1'b1;
            way_dirty[set][v] = wb;
            fifo_cnt[set]     = fifo_cnt[set] + way_t'(1);
        end else if (wb) begin
            way_dirty[set][hit_w] = 1'b1;
        end
        if (wb) wb_lines[la] = data;
        test_name    = name;
        exp_check    = !wb;
        exp_line     = ref_line(la);
        req_strobe_i = 1'b1;
        req_wb_i     = wb;
        req_addr_i   = a;
        req_data_i   = data;
        cycles       = 0;
        do begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) abort_run({"Timeout waiting for resp_ready_o in ", name});
        end while (!resp_ready_o);
        @(posedge clk_i);
        #2;
        req_strobe_i = 1'b0;                     // Drop in the cycle after ready
        req_wb_i     = 1'b0;
        req_addr_i   = '0;
        req_data_i   = '0;
        exp_check    = 1'b0;
        if (exp_rw.size() != 0) abort_run({"Expected memory access missing in ", name});
        @(posedge clk_i);
        #2;
    endtask

    // ====================================================================
    // Stimulus
    // ====================================================================
    initial begin : stimulus
        addr_t a;
        line_t d;
        req_strobe_i = 1'b0;
        req_wb_i     = 1'b0;
        req_addr_i   = '0;
        req_data_i   = '0;
        rst_i        = 1'b1;
        exp_check    = 1'b0;
        test_name    = "reset";
        for (int s = 0; s < N_SETS; s++) begin
            fifo_cnt[s] = '0;
            for (int w = 0; w < N_WAYS; w++) begin
                way_addr[s][w]  = '0;
                way_valid[s][w] = 1'b0;
                way_dirty[s][w] = 1'b0;
            end
        end
        repeat (10) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        for (int i = 0; i < 24; i++) begin       // Quiet while idle
            @(negedge clk_i);
            check_bit("idle ready", 1'b0, resp_ready_o);
            check_bit("idle mem strobe", 1'b0, m_strobe_o);
        end
        @(posedge clk_i);
        #2;

        do_request("first read", 1'b0, 32'h0000_1234, '0);   // Unaligned address in set 3
        do_request("re-read", 1'b0, 32'h0000_1238, '0);
        d = {4{32'hfeed_0001}};
        do_request("write-back hit", 1'b1, 32'h0000_1230, d);
        do_request("read after write-back", 1'b0, 32'h0000_1230, '0);

        // Five lines of set 5 where the dirty first one leaves first
        d = {4{32'hd1d1_0005}};
        do_request("fifo fill 0", 1'b0, 32'h0000_0050, '0);
        do_request("fifo dirty 0", 1'b1, 32'h0000_0050, d);
        for (int k = 1; k < 4; k++) begin
            do_request("fifo fill", 1'b0, 32'h0000_0050 + 32'(k) * 32'h100, '0);
        end
        do_request("fifo evict", 1'b0, 32'h0000_0450, '0);
        do_request("evicted re-read", 1'b0, 32'h0000_0050, '0);

        d = {4{32'hc1ea_0009}};
        do_request("write-back miss clean", 1'b1, 32'h0000_0290, d);
        do_request("read clean write-back", 1'b0, 32'h0000_0290, '0);

        // 24 lines over sets 10 to 12
        for (int i = 0; i < 300; i++) begin
            a = 32'h4000_0000 + (32'({$random(seed)} % 8) << 12)
                + (32'(10 + {$random(seed)} % 3) << 4) + 32'({$random(seed)} % 16);
            d = {$random(seed), $random(seed), $random(seed), $random(seed)};
            do_request("random", ($random(seed) & 1) == 1, a, d);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/l2_cache_pkg.sv
design/l2_array_if.sv
design/l2_tag_array.sv
design/l2_data_array.sv
design/l2_fifo_repl.sv
design/l2_ctrl.sv
design/l2_cache.sv
tb/tb_l2_cache.sv

/* run.sh */
#!/bin/sh
# Build and run the L2 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_l2_cache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_l2_cache 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
